//--- src.f
source/rom_check_pkg.sv
source/digest_pkg.sv
source/rom_addr_counter.sv
source/rom_word_fifo.sv
source/digest_engine.sv
source/digest_compare.sv
source/rom_check_fsm.sv
source/rom_check_top.sv
tb/rom_check_monitor.sv
tb/tb_rom_check.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_rom_check
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/tb_rom_check.sv
// Testbench top with clock, reset, ROM model, random ROM contents, pass sequence and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_rom_check
  import rom_check_pkg::*;
  import digest_pkg::*;
();

  localparam int RomDepth    = 64;
  localparam int DigestWords = 4;
  localparam int FifoDepth   = 4;
  localparam int AW          = $clog2(RomDepth);
  localparam int NumPasses   = 3;
  localparam int TailCycles  = 8;
  // Each pass reads every word in about two cycles, plus reset and compare time
  localparam int TimeoutCycles = 3 * NumPasses * (2 * RomDepth + DigestWords + 40);

  // Expected words set to the model digest, then one of them spoiled, then left random
  localparam int PassMatch = 0;
  localparam int PassFlip  = 1;
  localparam int PassFresh = 2;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      rom_req;
  logic [AW-1:0]             rom_addr;
  rom_word_t                 rom_data;
  logic                      done;
  logic                      good;
  logic                      alert;
  logic [DigestWords*32-1:0] digest;

  rom_word_t     rom_mem [RomDepth];
  logic [31:0]   model_lane [DigestWords];
  logic          req_seen;
  logic [AW-1:0] held_addr;
  integer        seed;
  int            cycles = 0;
  int            flow_errs;
  int            addr_errs, data_errs, ctrl_errs, alert_errs, results;

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  rom_check_top #(
    .RomDepth    (RomDepth),
    .DigestWords (DigestWords),
    .FifoDepth   (FifoDepth)
  ) dut_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rom_req_o  (rom_req),
    .rom_addr_o (rom_addr),
    .rom_data_i (rom_data),
    .done_o     (done),
    .good_o     (good),
    .digest_o   (digest),
    .alert_o    (alert)
  );

  rom_check_monitor #(
    .RomDepth    (RomDepth),
    .DigestWords (DigestWords)
  ) u_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rom_req_i    (rom_req),
    .rom_addr_i   (rom_addr),
    .rom_data_i   (rom_data),
    .done_i       (done),
    .good_i       (good),
    .digest_i     (digest),
    .alert_i      (alert),
    .addr_errs_o  (addr_errs),
    .data_errs_o  (data_errs),
    .ctrl_errs_o  (ctrl_errs),
    .alert_errs_o (alert_errs),
    .results_o    (results)
  );

  // ROM answers one cycle after the request, data changes on the falling edge
  always @(negedge clk_i) begin
    if (req_seen) begin
      rom_data <= rom_mem[held_addr];
    end
    req_seen  <= rom_req;
    held_addr <= rom_addr;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the checker never finished", TimeoutCycles);
      report_counts();
      $display("Some tests failed");
      $finish;
    end
  end

  // Rotate left, xor in the word, then add the seed of that lane
  function automatic logic [31:0] fold_lane(logic [31:0] lane, logic [31:0] word, int idx);
    logic [31:0] rotated;
    rotated = {lane[31-DigestRot:0], lane[31:32-DigestRot]};
    return (rotated ^ word) + DigestSeed[idx];
  endfunction

  task automatic compute_model();
    int lane;
    for (int l = 0; l < DigestWords; l++) begin
      model_lane[l] = DigestSeed[l];
    end
    for (int a = 0; a < RomDepth - DigestWords; a++) begin
      lane = a % DigestWords;
      model_lane[lane] = fold_lane(model_lane[lane], rom_mem[a], lane);
    end
  endtask

  task automatic fill_rom(input int kind);
    int lane;
    int bit_pos;
    for (int a = 0; a < RomDepth; a++) begin
      rom_mem[a] = $random(seed);
    end
    if (kind != PassFresh) begin
      compute_model();
      for (int l = 0; l < DigestWords; l++) begin
        rom_mem[RomDepth - DigestWords + l] = model_lane[l];
      end
    end
    // One bit of one expected word is enough to spoil the match
    if (kind == PassFlip) begin
      lane    = {$random(seed)} % DigestWords;
      bit_pos = {$random(seed)} % 32;
      rom_mem[RomDepth - DigestWords + lane] =
        rom_mem[RomDepth - DigestWords + lane] ^ (32'h1 << bit_pos);
    end
  endtask

  task automatic run_pass(input int kind);
    @(negedge clk_i);
    rst_ni = 1'b0;
    fill_rom(kind);
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    while (!done) begin
      @(negedge clk_i);
    end
    // A few more cycles so the monitor sees the held result
    repeat (TailCycles) @(negedge clk_i);
  endtask

  task automatic report_counts();
    $display("Errors: address %0d, data %0d, control %0d, alert %0d, flow %0d", addr_errs,
             data_errs, ctrl_errs, alert_errs, flow_errs);
  endtask

  initial begin
    seed      = 32'hbf3c;
    rst_ni    = 1'b0;
    rom_data  = '0;
    req_seen  = 1'b0;
    held_addr = '0;
    flow_errs = 0;
    run_pass(PassMatch);
    run_pass(PassFlip);
    run_pass(PassFresh);
    if (results != NumPasses) begin
      $display("The monitor checked %0d results instead of %0d", results, NumPasses);
      flow_errs = flow_errs + 1;
    end
    report_counts();
    if (addr_errs + data_errs + ctrl_errs + alert_errs + flow_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/rom_check_monitor.sv
// Testbench monitor with address order, digest and result models and error counters
`timescale 1ns/10ps
`default_nettype none

module rom_check_monitor
  import rom_check_pkg::*;
  import digest_pkg::*;
#(
  parameter int RomDepth    = 64,
  parameter int DigestWords = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rom_req_i,
  input  logic [$clog2(RomDepth)-1:0] rom_addr_i,
  input  rom_word_t                   rom_data_i,
  input  logic                        done_i,
  input  logic                        good_i,
  input  logic [DigestWords*32-1:0]   digest_i,
  input  logic                        alert_i,
  output int                          addr_errs_o,
  output int                          data_errs_o,
  output int                          ctrl_errs_o,
  output int                          alert_errs_o,
  output int                          results_o
);

  // Words below this ordinal are folded, the rest hold the expected digest
  localparam int LowWords = RomDepth - DigestWords;

  logic [31:0] lane_model [DigestWords];
  logic [31:0] exp_words [DigestWords];
  int          next_addr;
  int          words_seen;
  int          good_early;
  logic        pend;
  logic        done_seen;
  logic        good_held;
  logic        alert_prev;

  // Rotate left, xor in the word, then add the seed of that lane
  function automatic logic [31:0] lane_step(logic [31:0] lane, logic [31:0] word, int idx);
    logic [31:0] rotated;
    rotated = {lane[31-DigestRot:0], lane[31:32-DigestRot]};
    return (rotated ^ word) + DigestSeed[idx];
  endfunction

  task automatic clear_model();
    for (int l = 0; l < DigestWords; l++) begin
      lane_model[l] = DigestSeed[l];
      exp_words[l]  = '0;
    end
    next_addr  = 0;
    words_seen = 0;
    good_early = 0;
    pend       = 1'b0;
    done_seen  = 1'b0;
    good_held  = 1'b0;
    alert_prev = 1'b0;
  endtask

  // Words come back in request order, so the ordinal gives the ROM address
  task automatic take_word(input rom_word_t word);
    int lane;
    if (words_seen < LowWords) begin
      lane = words_seen % DigestWords;
      lane_model[lane] = lane_step(lane_model[lane], word, lane);
    end else if (words_seen < RomDepth) begin
      exp_words[words_seen - LowWords] = word;
    end
    words_seen = words_seen + 1;
  endtask

  task automatic check_result();
    logic        all_equal;
    logic [31:0] got;
    all_equal = 1'b1;
    if (words_seen != RomDepth) begin
      $display("At %0t done_o rose after only %0d of %0d ROM words", $time, words_seen,
               RomDepth);
      ctrl_errs_o = ctrl_errs_o + 1;
    end
    for (int l = 0; l < DigestWords; l++) begin
      got = digest_i[l*32 +: 32];
      if (got !== lane_model[l]) begin
        $display("Mismatch at %0t: digest lane %0d is %h, expected %h", $time, l, got,
                 lane_model[l]);
        data_errs_o = data_errs_o + 1;
      end
      if (exp_words[l] != lane_model[l]) begin
        all_equal = 1'b0;
      end
    end
    // The result is good only when every stored word matches its lane
    if (good_i !== all_equal) begin
      $display("Mismatch at %0t: good_o is %b, expected %b", $time, good_i, all_equal);
      data_errs_o = data_errs_o + 1;
    end
  endtask

  initial begin
    addr_errs_o  = 0;
    data_errs_o  = 0;
    ctrl_errs_o  = 0;
    alert_errs_o = 0;
    results_o    = 0;
  end

  // Sampled on the rising edge, where all values have been settled since the falling edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      clear_model();
      // The counter stays quiet while held in reset
      if (rom_req_i === 1'b1) begin
        $display("At %0t a ROM request was issued during reset", $time);
        addr_errs_o = addr_errs_o + 1;
      end
    end else begin
      // The ROM answers the request of the previous cycle
      if (pend) begin
        take_word(rom_data_i);
      end
      if (rom_req_i) begin
        if (next_addr >= RomDepth) begin
          $display("At %0t a ROM request came after the last address", $time);
          addr_errs_o = addr_errs_o + 1;
        end else if (int'(rom_addr_i) != next_addr) begin
          $display("Mismatch at %0t: ROM address %0d, expected %0d", $time, rom_addr_i,
                   next_addr);
          addr_errs_o = addr_errs_o + 1;
        end
        next_addr = next_addr + 1;
      end
      pend = rom_req_i;
      if (done_seen) begin
        // Result is frozen until the next reset
        if (!done_i || (good_i !== good_held)) begin
          $display("Mismatch at %0t: done_o %b good_o %b changed after completion", $time,
                   done_i, good_i);
          ctrl_errs_o = ctrl_errs_o + 1;
        end
      end else if (done_i) begin
        check_result();
        done_seen = 1'b1;
        good_held = good_i;
        results_o = results_o + 1;
      end else if (good_i) begin
        // good_o may lead done_o only by the one cycle the FSM takes to enter Done
        good_early = good_early + 1;
        if ((words_seen < RomDepth) || (good_early > 1)) begin
          $display("At %0t good_o went high before done_o", $time);
          ctrl_errs_o = ctrl_errs_o + 1;
        end
      end
      if (alert_i && !alert_prev) begin
        $display("At %0t alert_o went high", $time);
        alert_errs_o = alert_errs_o + 1;
      end
      alert_prev = alert_i;
    end
  end

endmodule

`default_nettype wire

//--- source/rom_check_top.sv
// Top level of the ROM integrity checker with counter, FIFO, engine, compare and FSM
`timescale 1ns/10ps
`default_nettype none

module rom_check_top
  import rom_check_pkg::*;
#(
  parameter int RomDepth    = 64,
  parameter int DigestWords = 4,
  parameter int FifoDepth   = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  output logic                        rom_req_o,
  output logic [$clog2(RomDepth)-1:0] rom_addr_o,
  input  rom_word_t                   rom_data_i,
  output logic                        done_o,
  output logic                        good_o,
  output logic [DigestWords*32-1:0]   digest_o,
  output logic                        alert_o
);

  logic                      push, push_top, ctr_done, credit;
  logic                      fifo_valid, fifo_top, eng_ready;
  rom_word_t                 fifo_data;
  logic [DigestWords*32-1:0] exp_digest;
  logic                      eng_done, start_cmp, cmp_done, cmp_alert;

  // Producer, walks the ROM while FIFO credits last
  rom_addr_counter #(
    .RomDepth    (RomDepth),
    .DigestWords (DigestWords),
    .FifoDepth   (FifoDepth)
  ) u_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .credit_i   (credit),
    .rom_req_o  (rom_req_o),
    .rom_addr_o (rom_addr_o),
    .push_o     (push),
    .top_o      (push_top),
    .done_o     (ctr_done)
  );

  // ROM data lands here together with the delayed push from the counter
  rom_word_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push),
    .top_i    (push_top),
    .data_i   (rom_data_i),
    .valid_o  (fifo_valid),
    .top_o    (fifo_top),
    .data_o   (fifo_data),
    .ready_i  (eng_ready),
    .credit_o (credit)
  );

  digest_engine #(
    .RomDepth    (RomDepth),
    .DigestWords (DigestWords)
  ) u_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (fifo_valid),
    .top_i        (fifo_top),
    .data_i       (fifo_data),
    .ready_o      (eng_ready),
    .digest_o     (digest_o),
    .exp_digest_o (exp_digest),
    .eng_done_o   (eng_done)
  );

  digest_compare #(
    .DigestWords (DigestWords)
  ) u_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_cmp),
    .digest_i     (digest_o),
    .exp_digest_i (exp_digest),
    .done_o       (cmp_done),
    .good_o       (good_o),
    .alert_o      (cmp_alert)
  );

  rom_check_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctr_done_i  (ctr_done),
    .eng_done_i  (eng_done),
    .cmp_done_i  (cmp_done),
    .cmp_alert_i (cmp_alert),
    .start_cmp_o (start_cmp),
    .done_o      (done_o),
    .alert_o     (alert_o)
  );

endmodule

`default_nettype wire

//--- source/rom_check_fsm.sv
// Main checker FSM with done-event consistency checks, compare start and alert
`timescale 1ns/10ps
`default_nettype none

module rom_check_fsm
  import rom_check_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ctr_done_i,
  input  logic eng_done_i,
  input  logic cmp_done_i,
  input  logic cmp_alert_i,
  output logic start_cmp_o,
  output logic done_o,
  output logic alert_o
);

  fsm_state_e state_q, state_d;
  logic       fsm_alert;
  logic       ctr_dropped;
  logic       start_q;

  // The counter done is sticky, so seeing it low once we are Done means the
  // address counter has been disturbed after the check
  assign ctr_dropped = (state_q == Done) && !ctr_done_i;

  // Linear progression from Reading through Draining and Checking to Done
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;

    unique case (state_q)
      Reading: begin
        if (ctr_done_i) begin
          state_d = Draining;
        end
      end
      Draining: begin
        if (eng_done_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end
      Done: begin
        // Terminal state where the result stays put
      end
      default: begin
        // Covers Invalid and any encoding outside the list
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
    endcase

    // Done events only make sense in the state that waits for them
    if ((eng_done_i && (state_q != Draining)) ||
        (cmp_done_i && (state_q != Checking))) begin
      state_d = Invalid;
    end

    // A compare alert or a dropped counter done also locks the FSM in Invalid
    if (cmp_alert_i || ctr_dropped) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Reading;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One pulse on the move into Checking
      start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  assign start_cmp_o = start_q;
  assign done_o      = (state_q == Done);
  assign alert_o     = fsm_alert | cmp_alert_i | ctr_dropped;

endmodule

`default_nettype wire

//--- source/digest_compare.sv
// Word-serial compare of the computed and expected digest, with done, result and alert
`timescale 1ns/10ps
`default_nettype none

module digest_compare
  import rom_check_pkg::*;
#(
  parameter int DigestWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic [DigestWords*32-1:0] digest_i,
  input  logic [DigestWords*32-1:0] exp_digest_i,
  output logic                      done_o,
  output logic                      good_o,
  output logic                      alert_o
);

  localparam int SW = (DigestWords > 1) ? $clog2(DigestWords) : 1;
  // One spare bit so an index past the lane range can be seen
  localparam int IW = SW + 1;
  localparam logic [IW-1:0] NumLanes = IW'(DigestWords);
  localparam logic [IW-1:0] LastIdx  = IW'(DigestWords - 1);

  logic [IW-1:0] idx_q;
  logic [SW-1:0] lane_sel;
  logic          busy_q, acc_q, done_q, good_q;
  rom_word_t     cur_dig, cur_exp;
  logic          lane_eq;

  assign lane_sel = idx_q[SW-1:0];
  assign cur_dig  = digest_i[lane_sel*32 +: 32];
  assign cur_exp  = exp_digest_i[lane_sel*32 +: 32];
  assign lane_eq  = (cur_dig == cur_exp);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q  <= '0;
      busy_q <= 1'b0;
      acc_q  <= 1'b0;
      done_q <= 1'b0;
      good_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
        acc_q  <= 1'b1;
      end else if (busy_q) begin
        // Any unequal lane clears the running result
        acc_q <= acc_q && lane_eq;
        idx_q <= idx_q + 1'b1;
        if (idx_q == LastIdx) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          // Result is held from here until reset
          good_q <= acc_q && lane_eq;
        end
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

  // A second start while busy, or a runaway index, means the control flow was upset
  assign alert_o = (busy_q && (idx_q >= NumLanes)) || (start_i && busy_q);

endmodule

`default_nettype wire

//--- source/digest_engine.sv
// Digest engine folding low ROM words into lanes and capturing the expected digest words
`timescale 1ns/10ps
`default_nettype none

module digest_engine
  import rom_check_pkg::*;
  import digest_pkg::*;
#(
  parameter int RomDepth    = 64,
  parameter int DigestWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      valid_i,
  input  logic                      top_i,
  input  rom_word_t                 data_i,
  output logic                      ready_o,
  output logic [DigestWords*32-1:0] digest_o,
  output logic [DigestWords*32-1:0] exp_digest_o,
  output logic                      eng_done_o
);

  localparam int LW = (DigestWords > 1) ? $clog2(DigestWords) : 1;
  localparam int NW = $clog2(RomDepth + 1);
  localparam logic [LW-1:0] LastLane = LW'(DigestWords - 1);
  localparam logic [NW-1:0] LastWord = NW'(RomDepth - 1);

  logic [31:0]   lane_q [DigestWords];
  logic [31:0]   exp_q [DigestWords];
  rom_word_t     word_q;
  logic          top_q, busy_q, all_taken_q;
  logic [LW-1:0] lane_idx_q, top_idx_q;
  logic [NW-1:0] taken_q;
  logic [2:0]    seed_idx;
  logic          take;

  // Accept a new word only while the fold unit is idle
  assign ready_o = !busy_q && !all_taken_q;
  assign take    = valid_i && ready_o;
  assign seed_idx = 3'(lane_idx_q);

  // Cycle one latches the word, cycle two folds or captures it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      top_q       <= 1'b0;
      all_taken_q <= 1'b0;
      lane_idx_q  <= '0;
      top_idx_q   <= '0;
      taken_q     <= '0;
      for (int i = 0; i < DigestWords; i++) begin
        lane_q[i] <= DigestSeed[i];
      end
    end else if (take) begin
      busy_q  <= 1'b1;
      top_q   <= top_i;
      taken_q <= taken_q + 1'b1;
      if (taken_q == LastWord) begin
        all_taken_q <= 1'b1;
      end
    end else if (busy_q) begin
      busy_q <= 1'b0;
      if (top_q) begin
        top_idx_q <= top_idx_q + 1'b1;
      end else begin
        // Low words go round the lanes in order
        lane_q[lane_idx_q] <= digest_fold(lane_q[lane_idx_q], word_q, seed_idx);
        lane_idx_q <= (lane_idx_q == LastLane) ? '0 : lane_idx_q + 1'b1;
      end
    end
  end

  // Word latch on take, and top words stored into their expected lane
  always_ff @(posedge clk_i) begin
    if (take) begin
      word_q <= data_i;
    end
    if (busy_q && top_q) begin
      exp_q[top_idx_q] <= word_q;
    end
  end

  // Lane 0 sits in the bottom 32 bits of both flat vectors
  for (genvar g = 0; g < DigestWords; g++) begin : g_flat
    assign digest_o[g*32 +: 32]     = lane_q[g];
    assign exp_digest_o[g*32 +: 32] = exp_q[g];
  end

  // High during the fold cycle of the final word
  assign eng_done_o = busy_q && all_taken_q;

endmodule

`default_nettype wire

//--- source/rom_word_fifo.sv
// Circular word buffer between ROM read data and the digest engine, with credit return
`timescale 1ns/10ps
`default_nettype none

module rom_word_fifo
  import rom_check_pkg::*;
#(
  parameter int FifoDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  logic      top_i,
  input  rom_word_t data_i,
  output logic      valid_o,
  output logic      top_o,
  output rom_word_t data_o,
  input  logic      ready_i,
  output logic      credit_o
);

  localparam int PW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CW = $clog2(FifoDepth + 1);
  localparam logic [PW-1:0] LastPtr = PW'(FifoDepth - 1);

  rom_word_t     mem_q [FifoDepth];
  logic          top_mem_q [FifoDepth];
  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          pop;

  assign valid_o = (count_q != '0);
  assign pop     = valid_o && ready_i;

  // Head of the buffer is shown directly, so a push is visible the cycle after
  assign data_o  = mem_q[rd_ptr_q];
  assign top_o   = top_mem_q[rd_ptr_q];

  // Each pop frees one slot and hands it back to the counter at once
  assign credit_o = pop;

  // Word and top flag storage, written at the tail on every push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q]     <= data_i;
      top_mem_q[wr_ptr_q] <= top_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // Credits keep pushes from ever landing on a full buffer
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/rom_addr_counter.sv
// ROM read address generator with credit-based flow control toward the word FIFO
`timescale 1ns/10ps
`default_nettype none

module rom_addr_counter #(
  parameter int RomDepth    = 64,
  parameter int DigestWords = 4,
  parameter int FifoDepth   = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        credit_i,
  output logic                        rom_req_o,
  output logic [$clog2(RomDepth)-1:0] rom_addr_o,
  output logic                        push_o,
  output logic                        top_o,
  output logic                        done_o
);

  localparam int AW = $clog2(RomDepth);
  localparam int CW = $clog2(FifoDepth + 1);
  localparam logic [AW-1:0] LastAddr = AW'(RomDepth - 1);
  localparam logic [AW-1:0] TopStart = AW'(RomDepth - DigestWords);
  localparam logic [CW-1:0] InitCredits = CW'(FifoDepth);

  logic [AW-1:0] addr_q;
  logic [CW-1:0] credit_q, credit_d;
  logic          run_q;
  logic          issued_q;
  logic          push_q, top_q, last_q, done_q;

  // A request needs a free FIFO slot, and the walk stops after the last address
  // Requests begin one cycle after reset is released
  assign rom_req_o  = run_q && (credit_q != '0) && !issued_q;
  assign rom_addr_o = addr_q;

  // One credit goes out with each request and one comes back with each FIFO pop
  always_comb begin
    credit_d = credit_q;
    if (credit_i) begin
      credit_d = credit_d + 1'b1;
    end
    if (rom_req_o) begin
      credit_d = credit_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      credit_q <= InitCredits;
      run_q    <= 1'b0;
      issued_q <= 1'b0;
      push_q   <= 1'b0;
      top_q    <= 1'b0;
      last_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      run_q    <= 1'b1;
      credit_q <= credit_d;
      // The ROM answers one cycle later, so the push and its tag trail the request
      push_q   <= rom_req_o;
      top_q    <= rom_req_o && (addr_q >= TopStart);
      last_q   <= rom_req_o && (addr_q == LastAddr);
      if (rom_req_o) begin
        if (addr_q == LastAddr) begin
          issued_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      // Sticky once the last word has been pushed
      if (last_q) begin
        done_q <= 1'b1;
      end
    end
  end

  assign push_o = push_q;
  assign top_o  = top_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

//--- source/digest_pkg.sv
// Digest lane seeds, rotate amount and the lane fold function
`default_nettype none

package digest_pkg;

  // Largest number of digest lanes the seed table supports
  parameter int DigestMaxLanes = 8;

  // Left rotate applied to a lane before each fold
  parameter int DigestRot = 5;

  // Start value of each lane, also added back in on every fold of that lane
  parameter logic [31:0] DigestSeed [DigestMaxLanes] = '{
    32'h6a09e667,
    32'hbb67ae85,
    32'h3c6ef372,
    32'ha54ff53a,
    32'h510e527f,
    32'h9b05688c,
    32'h1f83d9ab,
    32'h5be0cd19
  };

  // New lane value after folding in one data word
  // Rotate left by DigestRot, then xor the word, then add the seed of that lane
  function automatic logic [31:0] digest_fold(logic [31:0] lane, logic [31:0] word,
                                              logic [2:0] idx);
    logic [31:0] rot;
    rot = (lane << DigestRot) | (lane >> (32 - DigestRot));
    return (rot ^ word) + DigestSeed[idx];
  endfunction

endpackage

`default_nettype wire

//--- source/rom_check_pkg.sv
// ROM word type and main checker FSM state encoding
`default_nettype none

package rom_check_pkg;

  // Width of one word as read from the outside ROM
  parameter int RomWordWidth = 32;

  // A single ROM word, as carried from the ROM through the FIFO into the engine
  typedef logic [RomWordWidth-1:0] rom_word_t;

  // Main FSM states
  // The encodings sit at least two bit flips apart from each other, so a single upset
  // lands on a value that is not listed and sends the FSM to Invalid
  //
  //   Reading   counter still issuing requests or pushing words
  //   Draining  all words are in the FIFO, engine still folding
  //   Checking  compare walks the digest lanes
  //   Done      terminal, result held
  //   Invalid   terminal, alert raised
  typedef enum logic [5:0] {
    Reading  = 6'b101001,
    Draining = 6'b010110,
    Checking = 6'b111100,
    Done     = 6'b000111,
    Invalid  = 6'b100010
  } fsm_state_e;

endpackage

`default_nettype wire
